// ==== rtl/cache_stat_pkg.sv ====
package cache_stat_pkg;

	// byte address of a core request
	typedef logic [31:0] addr_t;

	// number of counted event kinds
	localparam int NUM_EVENTS = 6;

	// one strobe or flag per event
	typedef logic [NUM_EVENTS-1:0] event_vec_t;

	// bit positions, also the counter order in the frame
	localparam int EV_INST_READ  = 0;
	localparam int EV_INST_MISS  = 1;
	localparam int EV_DATA_READ  = 2;
	localparam int EV_DATA_WRITE = 3;
	localparam int EV_DATA_MISS  = 4;
	localparam int EV_L2_MISS    = 5;

	typedef logic [7:0] byte_t;

	// leads every frame
	localparam byte_t FRAME_SYNC = 8'hA5;

	// dump serializer states
	typedef enum logic [1:0] {
		IDLE,
		SEND,
		WAIT
	} ser_state_t;

endpackage

// ==== rtl/stat_bus_if.sv ====
`timescale 1ns/1ps

interface stat_bus_if #(
	parameter int COUNT_WIDTH = 16
);

	// one strobe per event, from the classifier
	cache_stat_pkg::event_vec_t events;

	// snapshot clear pulse
	logic clear;

	logic [COUNT_WIDTH-1:0] counts [cache_stat_pkg::NUM_EVENTS];

	// sticky saturation flags
	cache_stat_pkg::event_vec_t sat;

	modport classifier (output events);

	modport counter (input events, input clear, output counts, output sat);

	modport serializer (input counts, input sat, output clear);

endinterface

// ==== rtl/access_classifier.sv ====
`timescale 1ns/1ps

module access_classifier #(
	parameter cache_stat_pkg::addr_t INST_END_ADDR = 32'h0000_0A90
) (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  read_request,
	input  logic                  write_request,
	input  cache_stat_pkg::addr_t rw_address,
	input  logic                  l1i_miss,
	input  logic                  l1d_miss,
	input  logic                  l2_miss,
	stat_bus_if.classifier        bus
);

	logic read_q;
	logic write_q;
	logic l1i_miss_q;
	logic l1d_miss_q;
	logic l2_miss_q;
	cache_stat_pkg::addr_t address_q;
	logic inst_side;
	cache_stat_pkg::event_vec_t events_next;

	// one register stage on all inputs
	always_ff @(posedge clk_cpu) begin
		address_q <= rw_address;
		if (rst) begin
			read_q     <= 1'b0;
			write_q    <= 1'b0;
			l1i_miss_q <= 1'b0;
			l1d_miss_q <= 1'b0;
			l2_miss_q  <= 1'b0;
		end else begin
			read_q     <= read_request;
			write_q    <= write_request;
			l1i_miss_q <= l1i_miss;
			l1d_miss_q <= l1d_miss;
			l2_miss_q  <= l2_miss;
		end
	end

	// at or below the end address counts as instruction side
	assign inst_side = (address_q <= INST_END_ADDR);

	always_comb begin
		events_next = '0;
		events_next[cache_stat_pkg::EV_INST_READ]  = read_q & inst_side;
		events_next[cache_stat_pkg::EV_DATA_READ]  = read_q & ~inst_side;
		events_next[cache_stat_pkg::EV_DATA_WRITE] = write_q;
		events_next[cache_stat_pkg::EV_INST_MISS]  = l1i_miss_q;
		events_next[cache_stat_pkg::EV_DATA_MISS]  = l1d_miss_q;
		events_next[cache_stat_pkg::EV_L2_MISS]    = l2_miss_q;
	end

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			bus.events <= '0;
		end else begin
			bus.events <= events_next;
		end
	end

endmodule

// ==== rtl/event_counter.sv ====
`timescale 1ns/1ps

module event_counter #(
	parameter int COUNT_WIDTH = 16
) (
	input  logic                   clk_cpu,
	input  logic                   rst,
	input  logic                   event_strobe,
	input  logic                   clear,
	output logic [COUNT_WIDTH-1:0] count,
	output logic                   saturated
);

	localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			count     <= '0;
			saturated <= 1'b0;
		end else if (clear) begin
			// an event on the clear edge opens the next frame
			count     <= COUNT_WIDTH'(event_strobe);
			saturated <= 1'b0;
		end else if (event_strobe) begin
			if (count == COUNT_MAX) begin
				// event lost at the top sets the sticky flag
				saturated <= 1'b1;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/stat_dump_serializer.sv ====
`timescale 1ns/1ps

module stat_dump_serializer #(
	parameter int COUNT_WIDTH = 16
) (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  dump,
	stat_bus_if.serializer        bus,
	input  logic                  tx_busy,
	output cache_stat_pkg::byte_t tx_byte,
	output logic                  tx_start,
	output logic                  busy
);

	localparam int BYTES_PER_COUNT = COUNT_WIDTH / 8;
	// sync byte, sat byte, then all counters
	localparam int FRAME_LEN = 2 + cache_stat_pkg::NUM_EVENTS * BYTES_PER_COUNT;
	localparam int IDX_W = $clog2(FRAME_LEN);

	cache_stat_pkg::ser_state_t state;
	logic [IDX_W-1:0] byte_idx;
	logic [IDX_W-1:0] cnt_idx;
	cache_stat_pkg::byte_t frame_byte;

	// counter i at bits [i*COUNT_WIDTH +: COUNT_WIDTH] with its low byte first
	logic [cache_stat_pkg::NUM_EVENTS*COUNT_WIDTH-1:0] count_snap;
	cache_stat_pkg::event_vec_t sat_snap;

	// snapshot taken on the clear edge, so nothing counted before it is lost
	always_ff @(posedge clk_cpu) begin
		if (bus.clear) begin
			for (int i = 0; i < cache_stat_pkg::NUM_EVENTS; i++) begin
				count_snap[i*COUNT_WIDTH +: COUNT_WIDTH] <= bus.counts[i];
			end
			sat_snap <= bus.sat;
		end
	end

	always_comb begin
		cnt_idx = byte_idx - IDX_W'(2);
		if (byte_idx == '0) begin
			frame_byte = cache_stat_pkg::FRAME_SYNC;
		end else if (byte_idx == IDX_W'(1)) begin
			frame_byte = cache_stat_pkg::byte_t'(sat_snap);
		end else begin
			frame_byte = count_snap[cnt_idx*8 +: 8];
		end
	end

	// frame byte latched together with the start pulse
	always_ff @(posedge clk_cpu) begin
		if (state == cache_stat_pkg::SEND && !tx_busy) begin
			tx_byte <= frame_byte;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state     <= cache_stat_pkg::IDLE;
			byte_idx  <= '0;
			bus.clear <= 1'b0;
			tx_start  <= 1'b0;
			busy      <= 1'b0;
		end else begin
			bus.clear <= 1'b0;
			tx_start  <= 1'b0;
			case (state)
				cache_stat_pkg::IDLE: begin
					if (dump) begin
						bus.clear <= 1'b1;
						busy      <= 1'b1;
						byte_idx  <= '0;
						state     <= cache_stat_pkg::SEND;
					end
				end
				cache_stat_pkg::SEND: begin
					if (!tx_busy) begin
						tx_start <= 1'b1;
						state    <= cache_stat_pkg::WAIT;
					end
				end
				cache_stat_pkg::WAIT: begin
					// tx_busy only rises one edge after the start pulse
					if (!tx_start && !tx_busy) begin
						if (byte_idx == IDX_W'(FRAME_LEN - 1)) begin
							busy  <= 1'b0;
							state <= cache_stat_pkg::IDLE;
						end else begin
							byte_idx <= byte_idx + 1'b1;
							state    <= cache_stat_pkg::SEND;
						end
					end
				end
				default: begin
					state <= cache_stat_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  tx_start,
	input  cache_stat_pkg::byte_t tx_byte,
	output logic                  tx_busy,
	output logic                  tx_data
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	logic [CNT_W-1:0] clk_cnt;
	// bit periods finished across start, 8 data and stop bits
	logic [3:0] bit_cnt;
	cache_stat_pkg::byte_t shift_q;

	always_ff @(posedge clk_cpu) begin
		if (!tx_busy && tx_start) begin
			shift_q <= tx_byte;
		end else if (tx_busy && clk_cnt == CNT_W'(CLKS_PER_BIT - 1) && bit_cnt < 4'd8) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			tx_busy <= 1'b0;
			tx_data <= 1'b1;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				// start bit
				tx_busy <= 1'b1;
				tx_data <= 1'b0;
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
			clk_cnt <= '0;
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == 4'd9) begin
				// end of stop bit leaves the line high
				tx_busy <= 1'b0;
			end else if (bit_cnt == 4'd8) begin
				tx_data <= 1'b1;
			end else begin
				// lsb first
				tx_data <= shift_q[0];
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

// ==== rtl/cache_stat_monitor.sv ====
`timescale 1ns/1ps

module cache_stat_monitor #(
	parameter int                    COUNT_WIDTH   = 16,
	parameter cache_stat_pkg::addr_t INST_END_ADDR = 32'h0000_0A90,
	parameter int                    CLKS_PER_BIT  = 868
) (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  read_request,
	input  logic                  write_request,
	input  cache_stat_pkg::addr_t rw_address,
	input  logic                  l1i_miss,
	input  logic                  l1d_miss,
	input  logic                  l2_miss,
	input  logic                  dump,
	output logic                  tx_data,
	output logic                  busy
);

	cache_stat_pkg::byte_t tx_byte;
	logic tx_start;
	logic tx_busy;

	stat_bus_if #(.COUNT_WIDTH(COUNT_WIDTH)) bus ();

	access_classifier #(
		.INST_END_ADDR (INST_END_ADDR)
	) u_classifier (
		.clk_cpu       (clk_cpu),
		.rst           (rst),
		.read_request  (read_request),
		.write_request (write_request),
		.rw_address    (rw_address),
		.l1i_miss      (l1i_miss),
		.l1d_miss      (l1d_miss),
		.l2_miss       (l2_miss),
		.bus           (bus.classifier)
	);

	// one counter per event kind
	for (genvar i = 0; i < cache_stat_pkg::NUM_EVENTS; i++) begin : g_counter
		event_counter #(
			.COUNT_WIDTH (COUNT_WIDTH)
		) u_counter (
			.clk_cpu      (clk_cpu),
			.rst          (rst),
			.event_strobe (bus.events[i]),
			.clear        (bus.clear),
			.count        (bus.counts[i]),
			.saturated    (bus.sat[i])
		);
	end

	stat_dump_serializer #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_serializer (
		.clk_cpu  (clk_cpu),
		.rst      (rst),
		.dump     (dump),
		.bus      (bus.serializer),
		.tx_busy  (tx_busy),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.busy     (busy)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_tx (
		.clk_cpu  (clk_cpu),
		.rst      (rst),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_busy  (tx_busy),
		.tx_data  (tx_data)
	);

endmodule

// ==== verification/cache_stat_monitor_tb.sv ====
`timescale 1ns/1ps

module cache_stat_monitor_tb;

	localparam int CW = 8;
	localparam int CPB = 8;
	localparam cache_stat_pkg::addr_t INST_END = 32'h0000_0100;
	localparam int BPC = CW / 8;
	localparam int FRAME_LEN = 2 + cache_stat_pkg::NUM_EVENTS * BPC;
	localparam int CNT_MAX = (1 << CW) - 1;
	// six frames of about 700 cycles plus the stimulus and some margin
	localparam int MAX_CYCLES = 12000;

	logic clk_cpu;
	logic rst;
	logic read_request;
	logic write_request;
	cache_stat_pkg::addr_t rw_address;
	logic l1i_miss;
	logic l1d_miss;
	logic l2_miss;
	logic dump;
	logic tx_data;
	logic busy;
	// set with dump when the DUT is expected to take it
	logic dump_accept;

	integer seed;
	int value_errors;
	int other_errors;
	int cycle_count;
	int rx_count;
	int frames_expected;

	// model state
	int m_cnt [cache_stat_pkg::NUM_EVENTS];
	cache_stat_pkg::event_vec_t m_sat;
	cache_stat_pkg::event_vec_t stage1;
	cache_stat_pkg::event_vec_t stage2;
	logic clear_pend;

	cache_stat_pkg::byte_t exp_q [$];
	cache_stat_pkg::byte_t rx_q [$];
	event byte_received;

	cache_stat_monitor #(
		.COUNT_WIDTH   (CW),
		.INST_END_ADDR (INST_END),
		.CLKS_PER_BIT  (CPB)
	) DUT (
		.clk_cpu       (clk_cpu),
		.rst           (rst),
		.read_request  (read_request),
		.write_request (write_request),
		.rw_address    (rw_address),
		.l1i_miss      (l1i_miss),
		.l1d_miss      (l1d_miss),
		.l2_miss       (l2_miss),
		.dump          (dump),
		.tx_data       (tx_data),
		.busy          (busy)
	);

	always #10 clk_cpu = ~clk_cpu;

	function automatic cache_stat_pkg::event_vec_t classify(input logic rd, input logic wr,
			input cache_stat_pkg::addr_t addr, input logic im, input logic dm, input logic l2m);
		cache_stat_pkg::event_vec_t ev;
		ev = '0;
		// at or below the boundary is instruction traffic
		ev[cache_stat_pkg::EV_INST_READ]  = rd && (addr <= INST_END);
		ev[cache_stat_pkg::EV_DATA_READ]  = rd && (addr > INST_END);
		ev[cache_stat_pkg::EV_DATA_WRITE] = wr;
		ev[cache_stat_pkg::EV_INST_MISS]  = im;
		ev[cache_stat_pkg::EV_DATA_MISS]  = dm;
		ev[cache_stat_pkg::EV_L2_MISS]    = l2m;
		return ev;
	endfunction

	// frame byte idx from the model counters
	function automatic cache_stat_pkg::byte_t expected_byte(input int idx);
		cache_stat_pkg::byte_t b;
		int k;
		b = '0;
		k = idx - 2;
		if (idx == 0) begin
			b = cache_stat_pkg::FRAME_SYNC;
		end else if (idx == 1) begin
			b[cache_stat_pkg::NUM_EVENTS-1:0] = m_sat;
		end else begin
			b = 8'((m_cnt[k / BPC] >> (8 * (k % BPC))) & 255);
		end
		return b;
	endfunction

	// events reach the counters two edges after they are sampled
	always @(posedge clk_cpu) begin
		if (rst) begin
			for (int i = 0; i < cache_stat_pkg::NUM_EVENTS; i++) begin
				m_cnt[i] = 0;
			end
			m_sat = '0;
			stage1 = '0;
			stage2 = '0;
			clear_pend = 1'b0;
		end else begin
			if (clear_pend) begin
				for (int i = 0; i < FRAME_LEN; i++) begin
					exp_q.push_back(expected_byte(i));
				end
				frames_expected++;
				m_sat = '0;
			end
			for (int i = 0; i < cache_stat_pkg::NUM_EVENTS; i++) begin
				if (clear_pend) begin
					m_cnt[i] = stage2[i] ? 1 : 0;
				end else if (stage2[i]) begin
					if (m_cnt[i] == CNT_MAX) begin
						m_sat[i] = 1'b1;
					end else begin
						m_cnt[i]++;
					end
				end
			end
			clear_pend = dump && dump_accept;
			stage2 = stage1;
			stage1 = classify(read_request, write_request, rw_address,
				l1i_miss, l1d_miss, l2_miss);
		end
	end

	// uart receiver sampling near the middle of each bit
	initial begin : receiver
		cache_stat_pkg::byte_t data;
		forever begin
			@(negedge tx_data);
			if (!rst) begin
				repeat (CPB / 2) @(negedge clk_cpu);
				assert (tx_data == 1'b0) else begin
					$display("start bit did not stay low to its middle");
					other_errors++;
				end
				for (int i = 0; i < 8; i++) begin
					repeat (CPB) @(negedge clk_cpu);
					data[i] = tx_data;
				end
				repeat (CPB) @(negedge clk_cpu);
				assert (tx_data == 1'b1) else begin
					$display("stop bit was low");
					other_errors++;
				end
				if (rx_count % FRAME_LEN == FRAME_LEN - 1) begin
					assert (busy == 1'b1) else begin
						$display("busy dropped before the last stop bit of the frame");
						other_errors++;
					end
				end
				rx_count++;
				rx_q.push_back(data);
				-> byte_received;
			end
		end
	end

	initial begin : comparator
		cache_stat_pkg::byte_t got;
		cache_stat_pkg::byte_t want;
		forever begin
			@(byte_received);
			while (rx_q.size() > 0) begin
				got = rx_q.pop_front();
				if (exp_q.size() == 0) begin
					$display("byte %h arrived while no frame was expected", got);
					other_errors++;
				end else begin
					want = exp_q.pop_front();
					assert (got == want) else begin
						$display("Fail tx_data byte expected %h got %h", want, got);
						value_errors++;
					end
				end
			end
		end
	end

	always @(negedge busy) begin
		if (!rst) begin
			assert (rx_count % FRAME_LEN == 0) else begin
				$display("busy fell before the whole frame was sent");
				other_errors++;
			end
		end
	end

	always @(posedge clk_cpu) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("errors: %0d value, %0d other", value_errors, other_errors + 1);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic drive_cycle(input logic rd, input logic wr, input cache_stat_pkg::addr_t addr,
			input logic im, input logic dm, input logic l2m, input logic dmp, input logic acc);
		@(negedge clk_cpu);
		read_request = rd;
		write_request = wr;
		rw_address = addr;
		l1i_miss = im;
		l1d_miss = dm;
		l2_miss = l2m;
		dump = dmp;
		dump_accept = acc;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_cycle(0, 0, '0, 0, 0, 0, 0, 0);
	endtask

	task automatic dump_frame(input logic acc);
		drive_cycle(0, 0, '0, 0, 0, 0, 1, acc);
		idle_cycles(1);
	endtask

	task automatic wait_idle();
		while (busy) @(negedge clk_cpu);
	endtask

	task automatic check_quiet(input int n);
		repeat (n) begin
			@(negedge clk_cpu);
			assert (tx_data === 1'b1) else begin
				$display("Fail tx_data expected 1 got %h", tx_data);
				value_errors++;
			end
			assert (busy === 1'b0) else begin
				$display("Fail busy expected 0 got %h", busy);
				value_errors++;
			end
		end
	endtask

	task automatic random_traffic(input int n);
		cache_stat_pkg::addr_t addr;
		int pick;
		repeat (n) begin
			pick = $unsigned($random(seed)) % 6;
			case (pick)
				0: addr = 32'h0000_0000;
				1: addr = 32'h0000_00FC;
				2: addr = 32'h0000_0100;
				3: addr = 32'h0000_0104;
				4: addr = 32'h0000_0200;
				default: addr = $random(seed);
			endcase
			drive_cycle(($random(seed) & 1) != 0, ($random(seed) & 3) == 0, addr,
				($random(seed) & 7) == 0, ($random(seed) & 7) == 0,
				($random(seed) & 7) == 0, 0, 0);
		end
	endtask

	initial begin
		clk_cpu = 1'b0;
		rst = 1'b1;
		read_request = 1'b0;
		write_request = 1'b0;
		rw_address = '0;
		l1i_miss = 1'b0;
		l1d_miss = 1'b0;
		l2_miss = 1'b0;
		dump = 1'b0;
		dump_accept = 1'b0;
		seed = 48;
		repeat (4) @(posedge clk_cpu);
		@(negedge clk_cpu);
		rst = 1'b0;

		// line stays idle without a dump
		check_quiet(40);

		// mixed traffic on both sides of the boundary
		random_traffic(200);
		idle_cycles(2);
		dump_frame(1'b1);
		wait_idle();

		// saturate the instruction read counter and follow with an empty frame
		repeat (300) drive_cycle(1, 0, 32'h0000_0040, 0, 0, 0, 0, 0);
		idle_cycles(3);
		dump_frame(1'b1);
		wait_idle();
		dump_frame(1'b1);
		wait_idle();

		// events two, one and zero cycles before the dump edge
		drive_cycle(0, 0, '0, 1, 0, 0, 0, 0);
		drive_cycle(0, 0, '0, 0, 0, 1, 0, 0);
		drive_cycle(1, 1, 32'h0000_0100, 0, 1, 0, 1, 1);
		idle_cycles(1);
		wait_idle();
		dump_frame(1'b1);
		wait_idle();

		// a dump in the middle of a frame must be dropped
		random_traffic(20);
		dump_frame(1'b1);
		idle_cycles(100);
		dump_frame(1'b0);
		wait_idle();
		check_quiet(200);

		assert (exp_q.size() == 0) else begin
			$display("expected frame bytes never arrived");
			other_errors++;
		end
		assert (rx_count == frames_expected * FRAME_LEN) else begin
			$display("Fail rx_count expected %h got %h", frames_expected * FRAME_LEN, rx_count);
			value_errors++;
		end
		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== cache_stat_monitor.f ====
rtl/cache_stat_pkg.sv
rtl/stat_bus_if.sv
rtl/access_classifier.sv
rtl/event_counter.sv
rtl/stat_dump_serializer.sv
rtl/uart_tx.sv
rtl/cache_stat_monitor.sv
verification/cache_stat_monitor_tb.sv
